//--- design/ddc_pkg.sv
`default_nettype none

package ddc_pkg;

	// datapath widths
	localparam int SAMPLE_W = 16;   // adc and usb word width
	localparam int PHASE_W = 32;    // nco accumulator
	localparam int ANGLE_W = 16;    // top phase bits fed to the cordic

	// cordic rotator
	localparam int CORDIC_STAGES = 14;
	localparam int CORDIC_GUARD = 2;                            // fraction bits below the lsb
	localparam int CORDIC_W = SAMPLE_W + CORDIC_GUARD + 2;      // room for sign and 1.65x gain
	localparam int GAIN_W = 18;
	localparam int GAIN_FRAC = 16;
	localparam logic signed [GAIN_W-1:0] CORDIC_GAIN = 18'sd39797;  // 1/1.64676 in q16
	localparam int MIXER_LATENCY = CORDIC_STAGES + 2;            // pre-rotation + stages + gain

	// atan(2^-i), full turn = 2^16
	localparam logic [0:CORDIC_STAGES-1][ANGLE_W-1:0] CORDIC_ATAN = '{
		16'd8192, 16'd4836, 16'd2555, 16'd1297, 16'd651, 16'd326, 16'd163,
		16'd81, 16'd41, 16'd20, 16'd10, 16'd5, 16'd3, 16'd1
	};

	// cic decimator
	localparam int CIC_RATE = 8;
	localparam int CIC_ORDER = 3;
	localparam int CIC_GROWTH = 9;                  // order * log2(rate)
	localparam int CIC_W = SAMPLE_W + CIC_GROWTH;

	// serial register port
	localparam int FRAME_BITS = 40;                 // 8 address bits then 32 data bits
	localparam int REG_ADDR_W = 8;
	localparam logic [REG_ADDR_W-1:0] REG_FREQ = 8'h01;
	localparam logic [REG_ADDR_W-1:0] REG_OPTION = 8'h02;
	localparam int OPT_RUN = 2;                     // capture run bit in option reg

	localparam int FIFO_DEPTH = 16;

	typedef enum logic [1:0] {TAP_RAW = 2'd0, TAP_MIXED = 2'd1, TAP_DECIM = 2'd2,
		TAP_RSVD = 2'd3} tap_sel_e;

	typedef enum logic [1:0] {WR_IDLE = 2'd0, WR_Q = 2'd1, WR_I = 2'd2} wr_state_e;

endpackage

`default_nettype wire

//--- design/sample_fifo_if.sv
`default_nettype none

// head of the sample fifo as seen by the usb writer
interface sample_fifo_if import ddc_pkg::*; ();

	logic [SAMPLE_W-1:0] i_word;    // head entry, I half
	logic [SAMPLE_W-1:0] q_word;    // head entry, Q half
	logic empty;
	logic pop;                      // only while not empty, head moves next clock

	modport fifo (
		output i_word, q_word, empty,
		input pop
	);

	modport writer (
		input i_word, q_word, empty,
		output pop
	);

endinterface

`default_nettype wire

//--- design/ddc_ctrl_regs.sv
`default_nettype none

module ddc_ctrl_regs import ddc_pkg::*; (
	input logic ENC_CLK,
	input logic i_rst_n,
	input logic i_sck,
	input logic i_sdi,
	input logic i_cs_n,
	input logic [SAMPLE_W-1:0] i_adc,
	output logic [PHASE_W-1:0] o_phase_inc,
	output tap_sel_e o_tap_sel,
	output logic o_run,
	output logic [SAMPLE_W-1:0] o_adc_q
);

	logic [1:0] sck_sync;       // [0] newest sample
	logic [1:0] sdi_sync;
	logic [1:0] cs_sync;
	logic sck_rise;
	logic cs_rise;
	logic frame_ok;
	logic [FRAME_BITS-1:0] shift_q;             // msb first
	logic [$clog2(FRAME_BITS+1)-1:0] bit_cnt;   // saturates

	assign sck_rise = sck_sync[0] & ~sck_sync[1];
	assign cs_rise = cs_sync[0] & ~cs_sync[1];   // end of frame
	assign frame_ok = cs_rise && (bit_cnt == FRAME_BITS);

	// pin sync and control state
	always_ff @(posedge ENC_CLK) begin
		if (!i_rst_n) begin
			sck_sync <= 2'b00;
			cs_sync <= 2'b11;       // deselected
			bit_cnt <= '0;
			o_phase_inc <= '0;
			o_tap_sel <= TAP_RAW;
			o_run <= 1'b0;
		end else begin
			sck_sync <= {sck_sync[0], i_sck};
			cs_sync <= {cs_sync[0], i_cs_n};
			if (cs_sync[0])
				bit_cnt <= '0;  // idle between frames
			else if (sck_rise && bit_cnt != '1)
				bit_cnt <= bit_cnt + 1'b1;
			// short, long or unknown frames are dropped
			if (frame_ok) begin
				case (shift_q[FRAME_BITS-1 -: REG_ADDR_W])
					REG_FREQ: o_phase_inc <= shift_q[PHASE_W-1:0];
					REG_OPTION: begin
						o_tap_sel <= tap_sel_e'(shift_q[1:0]);
						o_run <= shift_q[OPT_RUN];
					end
					default: ;
				endcase
			end
		end
	end

	// data path, no reset
	always_ff @(posedge ENC_CLK) begin
		sdi_sync <= {sdi_sync[0], i_sdi};
		if (sck_rise && !cs_sync[0])
			shift_q <= {shift_q[FRAME_BITS-2:0], sdi_sync[1]}; // bit settled before sck rose
		o_adc_q <= i_adc;   // adc input register
	end

endmodule

`default_nettype wire

//--- design/ddc_nco_mixer.sv
`default_nettype none

module ddc_nco_mixer import ddc_pkg::*; (
	input logic ENC_CLK,
	input logic i_rst_n,
	input logic [PHASE_W-1:0] i_phase_inc,
	input logic [SAMPLE_W-1:0] i_sample,
	output logic [SAMPLE_W-1:0] o_i,
	output logic [SAMPLE_W-1:0] o_q,
	output logic o_strobe
);

	logic [PHASE_W-1:0] phase_acc;
	logic [ANGLE_W-1:0] theta;      // negated phase, mix down
	logic flip;                     // angle outside +-90 deg
	logic signed [CORDIC_W-1:0] x_ext;
	logic signed [CORDIC_W-1:0] xs [CORDIC_STAGES+1];
	logic signed [CORDIC_W-1:0] ys [CORDIC_STAGES+1];
	logic signed [ANGLE_W-1:0] zs [CORDIC_STAGES+1];   // residual angle
	logic signed [CORDIC_W+GAIN_W-1:0] prod_i;
	logic signed [CORDIC_W+GAIN_W-1:0] prod_q;
	logic [MIXER_LATENCY-1:0] valid_sr;

	// drop gain fraction and guard bits, clip to 16 bits
	function automatic logic [SAMPLE_W-1:0] saturate(input logic signed [CORDIC_W+GAIN_W-1:0] p);
		logic signed [CORDIC_W+GAIN_W-1:0] s;
		s = p >>> (GAIN_FRAC + CORDIC_GUARD);
		if (s > 32767)
			return 16'h7fff;
		else if (s < -32768)
			return 16'h8000;
		else
			return s[SAMPLE_W-1:0];
	endfunction

	assign theta = -phase_acc[PHASE_W-1 -: ANGLE_W];
	assign flip = theta[ANGLE_W-1] ^ theta[ANGLE_W-2];   // quadrants 2 and 3
	assign x_ext = {{(CORDIC_W-SAMPLE_W-CORDIC_GUARD){i_sample[SAMPLE_W-1]}}, i_sample,
		{CORDIC_GUARD{1'b0}}};
	assign prod_i = xs[CORDIC_STAGES] * CORDIC_GAIN;    // undo cordic gain
	assign prod_q = ys[CORDIC_STAGES] * CORDIC_GAIN;
	assign o_strobe = valid_sr[MIXER_LATENCY-1];

	// nco and pipeline fill
	always_ff @(posedge ENC_CLK) begin
		if (!i_rst_n) begin
			phase_acc <= '0;
			valid_sr <= '0;
		end else begin
			phase_acc <= phase_acc + i_phase_inc;
			valid_sr <= {valid_sr[MIXER_LATENCY-2:0], 1'b1};
		end
	end

	// rotator pipeline, one stage per clock
	always_ff @(posedge ENC_CLK) begin
		// pre-rotation by 180 deg keeps the residual inside cordic range
		xs[0] <= flip ? -x_ext : x_ext;
		ys[0] <= '0;        // real input
		zs[0] <= flip ? (theta ^ 16'h8000) : theta;
		for (int s = 0; s < CORDIC_STAGES; s++) begin
			if (!zs[s][ANGLE_W-1]) begin   // rotate ccw
				xs[s+1] <= xs[s] - (ys[s] >>> s);
				ys[s+1] <= ys[s] + (xs[s] >>> s);
				zs[s+1] <= zs[s] - CORDIC_ATAN[s];
			end else begin
				xs[s+1] <= xs[s] + (ys[s] >>> s);
				ys[s+1] <= ys[s] - (xs[s] >>> s);
				zs[s+1] <= zs[s] + CORDIC_ATAN[s];
			end
		end
		o_i <= saturate(prod_i);    // x cos(phi)
		o_q <= saturate(prod_q);    // -x sin(phi)
	end

endmodule

`default_nettype wire

//--- design/ddc_cic_decim.sv
`default_nettype none

module ddc_cic_decim import ddc_pkg::*; (
	input logic ENC_CLK,
	input logic i_rst_n,
	input logic [SAMPLE_W-1:0] i_i,
	input logic [SAMPLE_W-1:0] i_q,
	input logic i_strobe,
	output logic [SAMPLE_W-1:0] o_i,
	output logic [SAMPLE_W-1:0] o_q,
	output logic o_strobe
);

	// channel 0 is I, channel 1 is Q
	logic signed [CIC_W-1:0] in_ext [2];
	logic signed [CIC_W-1:0] integ [2][CIC_ORDER];
	logic signed [CIC_W-1:0] dly [2][CIC_ORDER];     // comb delays
	logic [SAMPLE_W-1:0] dec_out [2];
	logic [$clog2(CIC_RATE)-1:0] dec_cnt;

	assign in_ext[0] = {{CIC_GROWTH{i_i[SAMPLE_W-1]}}, i_i};
	assign in_ext[1] = {{CIC_GROWTH{i_q[SAMPLE_W-1]}}, i_q};
	assign o_i = dec_out[0];
	assign o_q = dec_out[1];

	// wraparound arithmetic throughout, combs cancel the overflow
	always_ff @(posedge ENC_CLK) begin
		logic signed [CIC_W-1:0] acc;
		if (!i_rst_n) begin
			dec_cnt <= '0;
			o_strobe <= 1'b0;
			for (int c = 0; c < 2; c++) begin
				for (int k = 0; k < CIC_ORDER; k++) begin
					integ[c][k] <= '0;
					dly[c][k] <= '0;
				end
			end
		end else begin
			o_strobe <= 1'b0;
			if (i_strobe) begin
				dec_cnt <= dec_cnt + 1'b1;      // wraps at rate
				for (int c = 0; c < 2; c++) begin
					integ[c][0] <= integ[c][0] + in_ext[c];
					for (int k = 1; k < CIC_ORDER; k++)
						integ[c][k] <= integ[c][k] + integ[c][k-1];
				end
				if (dec_cnt == CIC_RATE - 1) begin
					o_strobe <= 1'b1;
					for (int c = 0; c < 2; c++) begin
						acc = integ[c][CIC_ORDER-1];
						for (int k = 0; k < CIC_ORDER; k++) begin
							dly[c][k] <= acc;
							acc = acc - dly[c][k];  // comb at decimated rate
						end
						dec_out[c] <= acc[CIC_W-1 -: SAMPLE_W]; // divide by rate^order
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- design/ddc_sample_fifo.sv
`default_nettype none

module ddc_sample_fifo import ddc_pkg::*; (
	input logic ENC_CLK,
	input logic i_rst_n,
	input tap_sel_e i_tap_sel,
	input logic i_run,
	input logic [SAMPLE_W-1:0] i_raw,
	input logic [SAMPLE_W-1:0] i_mix_i,
	input logic [SAMPLE_W-1:0] i_mix_q,
	input logic i_mix_strobe,
	input logic [SAMPLE_W-1:0] i_dec_i,
	input logic [SAMPLE_W-1:0] i_dec_q,
	input logic i_dec_strobe,
	sample_fifo_if.fifo fifo_port,
	output logic o_overflow
);

	localparam int AW = $clog2(FIFO_DEPTH);

	logic [SAMPLE_W-1:0] sel_i, sel_q;
	logic sel_stb;
	logic [SAMPLE_W-1:0] mem_i [FIFO_DEPTH];
	logic [SAMPLE_W-1:0] mem_q [FIFO_DEPTH];
	logic [AW:0] wr_ptr, rd_ptr, used;  // extra wrap bit
	logic full, push;

	// tap mux
	always_comb begin
		case (i_tap_sel)
			TAP_MIXED: {sel_i, sel_q, sel_stb} = {i_mix_i, i_mix_q, i_mix_strobe};
			TAP_DECIM: {sel_i, sel_q, sel_stb} = {i_dec_i, i_dec_q, i_dec_strobe};
			default: {sel_i, sel_q, sel_stb} = {i_raw, {SAMPLE_W{1'b0}}, 1'b1}; // raw and reserved
		endcase
	end

	assign push = sel_stb & i_run;      // capture gate
	assign used = wr_ptr - rd_ptr;
	assign full = used[AW];
	assign fifo_port.empty = (used == '0);
	assign fifo_port.i_word = mem_i[rd_ptr[AW-1:0]];
	assign fifo_port.q_word = mem_q[rd_ptr[AW-1:0]];

	always_ff @(posedge ENC_CLK) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			o_overflow <= 1'b0;
		end else begin
			if (push && !full)
				wr_ptr <= wr_ptr + 1'b1;
			if (push && full)
				o_overflow <= 1'b1;     // sticky until reset
			if (fifo_port.pop && !fifo_port.empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge ENC_CLK) begin
		if (push && !full) begin
			mem_i[wr_ptr[AW-1:0]] <= sel_i;
			mem_q[wr_ptr[AW-1:0]] <= sel_q;
		end
	end

endmodule

`default_nettype wire

//--- design/ddc_fx2_writer.sv
`default_nettype none

module ddc_fx2_writer import ddc_pkg::*; (
	input logic ENC_CLK,
	input logic i_rst_n,
	sample_fifo_if.writer fifo_port,
	input logic i_flag_full_n,              // usb chip full flag, active low
	output logic [SAMPLE_W-1:0] o_fd,
	output logic o_slwr_n
);

	wr_state_e state;

	// head leaves the fifo while I is on the bus
	assign fifo_port.pop = (state == WR_I);

	// Q word first, then I, one pair per 3 clocks at best
	always_ff @(posedge ENC_CLK) begin
		if (!i_rst_n) begin
			state <= WR_IDLE;
			o_fd <= '0;
			o_slwr_n <= 1'b1;
		end else begin
			case (state)
				WR_IDLE: begin
					// full only blocks the start of a pair
					if (!fifo_port.empty && i_flag_full_n) begin
						o_fd <= fifo_port.q_word;
						o_slwr_n <= 1'b0;
						state <= WR_Q;
					end
				end
				WR_Q: begin
					o_fd <= fifo_port.i_word;   // second word of pair
					o_slwr_n <= 1'b0;
					state <= WR_I;
				end
				WR_I: begin
					o_slwr_n <= 1'b1;
					state <= WR_IDLE;
				end
				default: begin
					o_slwr_n <= 1'b1;
					state <= WR_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/ddc_rx_top.sv
`default_nettype none

module ddc_rx_top import ddc_pkg::*; (
	input logic ENC_CLK,
	input logic i_rst_n,
	input logic [SAMPLE_W-1:0] i_adc,
	input logic i_sck,
	input logic i_sdi,
	input logic i_cs_n,
	input logic i_flag_full_n,
	output logic [SAMPLE_W-1:0] o_fd,
	output logic o_slwr_n,
	output logic o_overflow
);

	logic [PHASE_W-1:0] phase_inc;      // tuning word
	tap_sel_e tap_sel;
	logic run;
	logic [SAMPLE_W-1:0] adc_q;
	logic [SAMPLE_W-1:0] mix_i, mix_q;
	logic mix_stb;
	logic [SAMPLE_W-1:0] dec_i, dec_q;
	logic dec_stb;

	sample_fifo_if fifo_bus ();         // fifo head to usb writer

	ddc_ctrl_regs u_regs (
		.ENC_CLK(ENC_CLK), .i_rst_n(i_rst_n),
		.i_sck(i_sck), .i_sdi(i_sdi), .i_cs_n(i_cs_n),
		.i_adc(i_adc),
		.o_phase_inc(phase_inc), .o_tap_sel(tap_sel), .o_run(run),
		.o_adc_q(adc_q)
	);

	ddc_nco_mixer u_mixer (
		.ENC_CLK(ENC_CLK), .i_rst_n(i_rst_n),
		.i_phase_inc(phase_inc), .i_sample(adc_q),
		.o_i(mix_i), .o_q(mix_q), .o_strobe(mix_stb)
	);

	ddc_cic_decim u_cic (
		.ENC_CLK(ENC_CLK), .i_rst_n(i_rst_n),
		.i_i(mix_i), .i_q(mix_q), .i_strobe(mix_stb),
		.o_i(dec_i), .o_q(dec_q), .o_strobe(dec_stb)
	);

	// raw tap takes the registered adc word
	ddc_sample_fifo u_fifo (
		.ENC_CLK(ENC_CLK), .i_rst_n(i_rst_n),
		.i_tap_sel(tap_sel), .i_run(run),
		.i_raw(adc_q),
		.i_mix_i(mix_i), .i_mix_q(mix_q), .i_mix_strobe(mix_stb),
		.i_dec_i(dec_i), .i_dec_q(dec_q), .i_dec_strobe(dec_stb),
		.fifo_port(fifo_bus.fifo),
		.o_overflow(o_overflow)
	);

	ddc_fx2_writer u_writer (
		.ENC_CLK(ENC_CLK), .i_rst_n(i_rst_n),
		.fifo_port(fifo_bus.writer),
		.i_flag_full_n(i_flag_full_n),
		.o_fd(o_fd), .o_slwr_n(o_slwr_n)
	);

endmodule

`default_nettype wire

//--- sim/ddc_rx_checker.sv
`default_nettype none

module ddc_rx_checker import ddc_pkg::*; (
	input logic ENC_CLK,
	input logic [SAMPLE_W-1:0] i_adc,
	input logic [SAMPLE_W-1:0] i_fd,
	input logic i_slwr_n,
	input logic i_overflow,
	input logic i_flag_full_n,
	input logic i_test_active,      // per-test window from the testbench
	input logic i_quiet,            // no pairs allowed
	input logic [1:0] i_kind,       // 0 raw order, 1 constant, 2 quarter turn
	input tap_sel_e i_tap,
	input logic signed [SAMPLE_W-1:0] i_exp_d,
	input int i_tol,
	input int i_count,
	input int i_test_no,
	output int o_pair_cnt,
	output int o_pass_cnt,
	output int o_fail_cnt
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [SAMPLE_W-1:0] hist [$];  // adc words seen this test
	logic [SAMPLE_W-1:0] q_word;
	logic slwr_last = 1'b1;
	logic flag_last = 1'b1;
	logic in_pair = 1'b0;
	logic active_last = 1'b0;
	int last_idx, phase_k, errs, cyc, last_start;

	initial begin
		o_pair_cnt = 0;
		o_pass_cnt = 0;
		o_fail_cnt = 0;
		cyc = 0;
	end

	function automatic bit near(input logic [SAMPLE_W-1:0] got, input int expv, input int t);
		int g;
		g = int'($signed(got));
		return (g - expv <= t) && (expv - g <= t);
	endfunction

	// quarter-turn points when mixing down (D,0) (0,-D) (-D,0) (0,D)
	function automatic bit on_point(input logic [15:0] qv, input logic [15:0] iv, input int k);
		int d;
		d = int'(i_exp_d);
		case (k)
			0: return near(iv, d, i_tol) && near(qv, 0, i_tol);
			1: return near(iv, 0, i_tol) && near(qv, -d, i_tol);
			2: return near(iv, -d, i_tol) && near(qv, 0, i_tol);
			default: return near(iv, 0, i_tol) && near(qv, d, i_tol);
		endcase
	endfunction

	task automatic report(input string msg);
		$display("CHECK FAILED at %0t: test %0d pair %0d %s", $time, i_test_no, o_pair_cnt,
			msg);
		errs++;
	endtask

	task automatic check_pair(input logic [15:0] qv, input logic [15:0] iv);
		int found;
		if (i_kind == 2'd0) begin
			found = -1;
			if (qv != '0)
				report($sformatf("raw Q word %h not zero", qv));
			for (int n = last_idx + 1; n < hist.size() && found < 0; n++)
				if (hist[n] == iv)
					found = n;
			if (found < 0)
				report($sformatf("I word %h not found after last sample", iv));
			else
				last_idx = found;
		end else if (i_kind == 2'd1) begin
			// decimated stream needs three outputs to settle
			if (!(i_tap == TAP_DECIM && o_pair_cnt < 3) && !(near(iv, int'(i_exp_d), i_tol)
				&& near(qv, 0, i_tol)))
				report($sformatf("got I %h Q %h, want near %h and 0", iv, qv, i_exp_d));
		end else begin
			if (o_pair_cnt == 0) begin
				phase_k = -1;
				for (int k = 3; k >= 0; k--)
					if (on_point(qv, iv, k))
						phase_k = k;
				if (phase_k < 0)
					report($sformatf("first pair I %h Q %h on no quarter point", iv, qv));
			end else if (phase_k >= 0) begin
				phase_k = (phase_k + 1) % 4;
				if (!on_point(qv, iv, phase_k))
					report($sformatf("I %h Q %h off quarter point %0d", iv, qv, phase_k));
			end
		end
	endtask

	always @(posedge ENC_CLK) begin
		cyc++;
		if (i_test_active && !active_last) begin
			hist.delete();
			last_idx = -1;
			errs = 0;
			o_pair_cnt = 0;
			if (i_overflow)
				report("overflow flag set before capture started");
		end
		if (i_test_active)
			hist.push_back(i_adc);  // word the adc register takes at this edge
		if (!i_slwr_n && slwr_last) begin
			if (!flag_last)
				report("pair started while the usb fifo flag said full");
			if (i_quiet)
				report("pair arrived after capture was stopped and drained");
			if (i_test_active && i_tap == TAP_DECIM && o_pair_cnt > 0 && o_pair_cnt < i_count
				&& cyc - last_start < CIC_RATE)
				report($sformatf("pairs only %0d cycles apart", cyc - last_start));
			last_start = cyc;
			q_word = i_fd;  // Q goes first
			in_pair = 1'b1;
		end else if (in_pair) begin
			in_pair = 1'b0;
			if (i_test_active) begin
				// quarter-turn order only holds until the fifo drops samples
				if (i_kind != 2'd2 || o_pair_cnt < i_count)
					check_pair(q_word, i_fd);
				o_pair_cnt++;
			end
		end
		if (!i_test_active && active_last) begin
			// raw and mixed taps push each cycle and outrun the 3-cycle writer
			if (i_overflow != (i_tap != TAP_DECIM))
				report($sformatf("overflow flag %0b at end of capture", i_overflow));
			$display("test %0d: %0d pairs, %0d errors, %s", i_test_no, o_pair_cnt, errs,
				(errs == 0) ? "ok" : "bad");
			if (errs == 0)
				o_pass_cnt++;
			else
				o_fail_cnt++;
		end
		flag_last = i_flag_full_n;
		slwr_last = i_slwr_n;
		active_last = i_test_active;
	end

endmodule

`default_nettype wire

//--- sim/tb_ddc_rx.sv
`default_nettype none

module tb_ddc_rx import ddc_pkg::*; ;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NROWS = 6;
	localparam int ROW_OVERHEAD = 2100;     // serial writes, settle, drain per row

	typedef struct packed {
		logic [31:0] tune;
		logic [1:0] tap;
		logic lcg;                  // else constant adc_d
		logic [15:0] adc_d;
		logic bp;                   // flag full in 40-cycle stretches
		int count;
		logic [1:0] kind;
		int tol;
		logic bad_frames;           // short frame and unknown address before the quiet check
	} row_t;

	row_t rows [NROWS] = '{
		'{32'h0000_0000, TAP_RAW, 1'b1, 16'h0000, 1'b0, 40, 2'd0, 0, 1'b0},
		'{32'h0000_0000, TAP_MIXED, 1'b0, 16'd1000, 1'b0, 12, 2'd1, 4, 1'b0},
		'{32'h4000_0000, TAP_MIXED, 1'b0, 16'd6000, 1'b0, 16, 2'd2, 4, 1'b0},
		'{32'h0000_0000, TAP_DECIM, 1'b0, 16'hf448, 1'b0, 10, 2'd1, 4, 1'b0},
		'{32'h0000_0000, TAP_RAW, 1'b1, 16'h0000, 1'b1, 40, 2'd0, 0, 1'b0},
		'{32'h4000_0000, TAP_RAW, 1'b1, 16'h0000, 1'b0, 20, 2'd0, 0, 1'b1}
	};

	logic ENC_CLK = 1'b0;
	logic i_rst_n = 1'b0;
	logic [15:0] i_adc = '0;
	logic i_sck = 1'b0;
	logic i_sdi = 1'b0;
	logic i_cs_n = 1'b1;
	logic i_flag_full_n = 1'b1;
	logic [15:0] o_fd;
	logic o_slwr_n, o_overflow;

	row_t cur = '0;
	logic test_active = 1'b0;
	logic quiet = 1'b0;
	logic bp_on = 1'b0;
	int test_no = 0;
	int pair_cnt, pass_cnt, fail_cnt;
	int want_pairs = 0;
	int cycles = 0;
	int limit = 0;
	logic [31:0] lcg_state = 32'd47;

	always #4 ENC_CLK = ~ENC_CLK;

	ddc_rx_top uut (.*);

	ddc_rx_checker chk (
		.ENC_CLK, .i_adc, .i_fd(o_fd), .i_slwr_n(o_slwr_n), .i_overflow(o_overflow),
		.i_flag_full_n,
		.i_test_active(test_active), .i_quiet(quiet), .i_kind(cur.kind),
		.i_tap(tap_sel_e'(cur.tap)), .i_exp_d(cur.adc_d), .i_tol(cur.tol),
		.i_count(cur.count), .i_test_no(test_no),
		.o_pair_cnt(pair_cnt), .o_pass_cnt(pass_cnt), .o_fail_cnt(fail_cnt)
	);

	function automatic logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[31:16];    // upper bits have the longer period
	endfunction

	// adc and usb flag change on the falling edge
	always @(negedge ENC_CLK) begin
		i_adc <= cur.lcg ? lcg_next() : cur.adc_d;
		i_flag_full_n <= bp_on ? ((cycles / 40) % 2 == 1) : 1'b1;
	end

	always @(posedge ENC_CLK) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("run timed out after %0d cycles, pairs stopped arriving", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	// 8 address bits then 32 data bits, msb first, 4 clocks per sck half
	task automatic send_frame(input logic [39:0] frame, input int nbits);
		i_cs_n = 1'b0;
		repeat (4) @(negedge ENC_CLK);
		for (int b = nbits - 1; b >= 0; b--) begin
			i_sdi = frame[b];
			i_sck = 1'b0;
			repeat (4) @(negedge ENC_CLK);
			i_sck = 1'b1;
			repeat (4) @(negedge ENC_CLK);
		end
		i_sck = 1'b0;
		repeat (4) @(negedge ENC_CLK);
		i_cs_n = 1'b1;
		repeat (8) @(negedge ENC_CLK);
	endtask

	task automatic write_option(input logic [1:0] tap, input logic run);
		send_frame({REG_OPTION, 29'd0, run, tap}, FRAME_BITS);
	endtask

	initial begin
		for (int r = 0; r < NROWS; r++)
			limit += rows[r].count * 3 * 8 + ROW_OVERHEAD;
		limit *= 2;
		for (int r = 0; r < NROWS; r++) begin
			@(negedge ENC_CLK);
			cur = rows[r];
			test_no = r + 1;
			i_rst_n = 1'b0;     // overflow flag is sticky until reset
			repeat (8) @(negedge ENC_CLK);
			i_rst_n = 1'b1;
			send_frame({REG_FREQ, cur.tune}, FRAME_BITS);
			write_option(cur.tap, 1'b0);
			repeat (64) @(negedge ENC_CLK);     // mixer and cic settle on the new input
			test_active = 1'b1;
			bp_on = cur.bp;
			write_option(cur.tap, 1'b1);
			want_pairs = cur.count;
			if (cur.bad_frames) begin
				// would switch to the mixed tap if accepted
				send_frame({REG_OPTION, 29'd0, 1'b1, 2'(TAP_MIXED)}, FRAME_BITS - 1);
				send_frame({8'h03, 29'd0, 1'b1, 2'(TAP_MIXED)}, FRAME_BITS);
				want_pairs = pair_cnt + cur.count;  // raw pairs keep coming afterwards
			end
			while (pair_cnt < want_pairs)
				@(negedge ENC_CLK);
			write_option(cur.tap, 1'b0);
			bp_on = 1'b0;
			repeat (120) @(negedge ENC_CLK);    // fifo drains
			if (cur.bad_frames) begin
				quiet = 1'b1;
				repeat (100) @(negedge ENC_CLK);
				quiet = 1'b0;
			end
			test_active = 1'b0;
			repeat (2) @(negedge ENC_CLK);
		end
		$display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && pass_cnt == NROWS)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
design/ddc_pkg.sv
design/sample_fifo_if.sv
design/ddc_ctrl_regs.sv
design/ddc_nco_mixer.sv
design/ddc_cic_decim.sv
design/ddc_sample_fifo.sv
design/ddc_fx2_writer.sv
design/ddc_rx_top.sv
sim/ddc_rx_checker.sv
sim/tb_ddc_rx.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ddc receiver testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_ddc_rx -o tb_ddc_rx

./obj_dir/tb_ddc_rx > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
	echo "run ended without a result line"
	exit 1
fi
exit 0
